// File: verilog/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// address map
`define SOC_MEM_BASE 32'h8000_0000
`define SOC_UART_ADDR 32'h1000_0000

// sram depth in 64-bit words
`define SOC_MEM_WORDS_LOG2 8
`define SOC_MEM_WORDS (1 << `SOC_MEM_WORDS_LOG2)

// uart character fifo
`define SOC_UART_DEPTH_LOG2 2
`define SOC_UART_DEPTH (1 << `SOC_UART_DEPTH_LOG2)

// 1 lets the lfsr hold off request acceptance, 0 never stalls
`define SOC_STALL_ENABLE 1

`endif

// File: verilog/axi_pkg.sv
`default_nettype none

`include "soc_defs.svh"

package axi_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0] {
    TGT_MEM  = 2'd0,
    TGT_UART = 2'd1,
    TGT_NONE = 2'd2
  } target_e;

  typedef struct packed {
    logic [3:0]  id;
    logic [31:0] addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
  } axi_ar_t;

  // aw carries the same fields as ar
  typedef axi_ar_t axi_aw_t;

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  strb;
    logic        last;
  } axi_w_t;

  typedef struct packed {
    logic [3:0]  id;
    logic [63:0] data;
    axi_resp_e   resp;
    logic        last;
  } axi_r_t;

  typedef struct packed {
    logic [3:0] id;
    axi_resp_e  resp;
  } axi_b_t;

  typedef struct packed {
    logic                           is_write;
    logic [3:0]                     id;
    logic [`SOC_MEM_WORDS_LOG2-1:0] idx;
    logic [63:0]                    data;
    logic [7:0]                     strb;
    target_e                        target;
    axi_resp_e                      err;
  } mem_req_t;

  typedef struct packed {
    logic        is_write;
    logic [3:0]  id;
    logic [63:0] data;
    axi_resp_e   resp;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: verilog/stall_lfsr.sv
`default_nettype none
`timescale 1ns/1ps

`include "soc_defs.svh"

module stall_lfsr (
  input  logic clk,
  input  logic rst_i,
  output logic go_o
);

  localparam logic [19:0] SEED = 20'd101;

  logic [19:0] lfsr;

  // taps 19 and 18, never reaches zero from a non-zero seed
  always_ff @(posedge clk) begin
    if (rst_i) begin
      lfsr <= SEED;
    end else begin
      lfsr <= {lfsr[18:0], lfsr[19] ^ lfsr[18]};
    end
  end

  assign go_o = (`SOC_STALL_ENABLE != 0) ? lfsr[19] : 1'b1;

endmodule

`default_nettype wire

// File: verilog/axi_req_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "soc_defs.svh"

module axi_req_stage (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               go_i,
  input  logic               ar_valid_i,
  input  axi_pkg::axi_ar_t   ar_i,
  output logic               ar_ready_o,
  input  logic               aw_valid_i,
  input  axi_pkg::axi_aw_t   aw_i,
  output logic               aw_ready_o,
  input  logic               w_valid_i,
  input  axi_pkg::axi_w_t    w_i,
  output logic               w_ready_o,
  output logic               req_valid_o,
  output axi_pkg::mem_req_t  req_o,
  input  logic               req_ready_i
);

  import axi_pkg::*;

  localparam int          IDX_HI   = `SOC_MEM_WORDS_LOG2 + 2;
  localparam logic [31:0] MEM_BASE = `SOC_MEM_BASE;
  localparam logic [31:0] UART_ADR = `SOC_UART_ADDR;

  logic        rd_pend;
  logic        wr_pend;
  logic        pick_wr;
  logic        can_acc;
  logic        acc;
  logic        prio_wr;
  logic [31:0] addr;
  logic [7:0]  len;
  mem_req_t    nxt;

  // a write needs both aw and w
  assign rd_pend = ar_valid_i;
  assign wr_pend = aw_valid_i && w_valid_i;
  assign pick_wr = wr_pend && (!rd_pend || prio_wr);
  assign can_acc = go_i && (!req_valid_o || req_ready_i);

  assign ar_ready_o = can_acc && rd_pend && !pick_wr;
  assign aw_ready_o = can_acc && pick_wr;
  assign w_ready_o  = can_acc && pick_wr;
  assign acc        = can_acc && (rd_pend || wr_pend);

  always_comb begin
    addr         = pick_wr ? aw_i.addr : ar_i.addr;
    len          = pick_wr ? aw_i.len : ar_i.len;
    nxt.is_write = pick_wr;
    nxt.id       = pick_wr ? aw_i.id : ar_i.id;
    nxt.idx      = addr[IDX_HI:3];
    nxt.data     = w_i.data;
    nxt.strb     = w_i.strb;
    // bursts and split writes are refused before decode
    if (len != 8'd0 || (pick_wr && !w_i.last)) begin
      nxt.target = TGT_NONE;
      nxt.err    = SLVERR;
    end else if (addr[31:IDX_HI+1] == MEM_BASE[31:IDX_HI+1]) begin
      nxt.target = TGT_MEM;
      nxt.err    = OKAY;
    end else if (addr == UART_ADR) begin
      nxt.target = TGT_UART;
      nxt.err    = OKAY;
    end else begin
      nxt.target = TGT_NONE;
      nxt.err    = DECERR;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      req_valid_o <= 1'b0;
      prio_wr     <= 1'b0;
    end else begin
      if (acc) begin
        req_valid_o <= 1'b1;
      end else if (req_ready_i) begin
        req_valid_o <= 1'b0;
      end
      // alternate only when both sides compete
      if (acc && rd_pend && wr_pend) begin
        prio_wr <= ~prio_wr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc) begin
      req_o <= nxt;
    end
  end

endmodule

`default_nettype wire

// File: verilog/mem_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "soc_defs.svh"

module mem_stage (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               req_valid_i,
  input  axi_pkg::mem_req_t  req_i,
  output logic               req_ready_o,
  output logic               rsp_valid_o,
  output axi_pkg::mem_rsp_t  rsp_o,
  input  logic               rsp_ready_i,
  output logic               chr_valid_o,
  output logic [7:0]         chr_o,
  input  logic               chr_ready_i
);

  import axi_pkg::*;

  logic [63:0] mem [`SOC_MEM_WORDS];

  logic out_free;
  logic is_uart_wr;
  logic is_mem_wr;
  logic is_mem_rd;
  logic acc;

  // errored requests carry TGT_NONE, so they match none of these
  assign is_uart_wr = req_i.is_write && (req_i.target == TGT_UART);
  assign is_mem_wr  = req_i.is_write && (req_i.target == TGT_MEM);
  assign is_mem_rd  = !req_i.is_write && (req_i.target == TGT_MEM);

  assign out_free    = !rsp_valid_o || rsp_ready_i;
  assign req_ready_o = out_free && (!is_uart_wr || chr_ready_i);
  assign acc         = req_valid_i && req_ready_o;

  // char is pushed in the same cycle the request moves on
  assign chr_valid_o = req_valid_i && is_uart_wr && out_free;
  assign chr_o       = req_i.data[7:0];

  always_ff @(posedge clk) begin
    if (acc && is_mem_wr) begin
      for (int b = 0; b < 8; b++) begin
        if (req_i.strb[b]) begin
          mem[req_i.idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc) begin
      rsp_o.is_write <= req_i.is_write;
      rsp_o.id       <= req_i.id;
      rsp_o.resp     <= req_i.err;
      // uart reads, writes and errors return zero data
      rsp_o.data     <= is_mem_rd ? mem[req_i.idx] : 64'd0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
    end else if (acc) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_tx_port.sv
`default_nettype none
`timescale 1ns/1ps

`include "soc_defs.svh"

module uart_tx_port (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       chr_valid_i,
  input  logic [7:0] chr_i,
  output logic       chr_ready_o,
  output logic [7:0] uart_char_o,
  output logic       uart_valid_o,
  input  logic       uart_ready_i
);

  logic [7:0]                      fifo [`SOC_UART_DEPTH];
  logic [`SOC_UART_DEPTH_LOG2-1:0] wr_ptr;
  logic [`SOC_UART_DEPTH_LOG2-1:0] rd_ptr;
  logic [`SOC_UART_DEPTH_LOG2-1:0] wr_nxt;
  logic                            full;
  logic                            push;
  logic                            pop;

  assign chr_ready_o  = !full;
  assign uart_valid_o = full || (wr_ptr != rd_ptr);
  assign uart_char_o  = fifo[rd_ptr];

  assign push   = chr_valid_i && chr_ready_o;
  assign pop    = uart_valid_o && uart_ready_i;
  assign wr_nxt = wr_ptr + 1'b1;

  always_ff @(posedge clk) begin
    if (push) begin
      fifo[wr_ptr] <= chr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      full   <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_nxt;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // full only when a push catches up with the read side
      if (push && !pop && wr_nxt == rd_ptr) begin
        full <= 1'b1;
      end else if (pop && !push) begin
        full <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/axi_resp_stage.sv
`default_nettype none
`timescale 1ns/1ps

module axi_resp_stage (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               rsp_valid_i,
  input  axi_pkg::mem_rsp_t  rsp_i,
  output logic               rsp_ready_o,
  output logic               r_valid_o,
  output axi_pkg::axi_r_t    r_o,
  input  logic               r_ready_i,
  output logic               b_valid_o,
  output axi_pkg::axi_b_t    b_o,
  input  logic               b_ready_i
);

  import axi_pkg::*;

  mem_rsp_t hold;
  logic     hold_valid;
  logic     out_acc;
  logic     load;

  assign r_valid_o = hold_valid && !hold.is_write;
  assign b_valid_o = hold_valid && hold.is_write;

  assign out_acc     = (r_valid_o && r_ready_i) || (b_valid_o && b_ready_i);
  assign rsp_ready_o = !hold_valid || out_acc;
  assign load        = rsp_valid_i && rsp_ready_o;

  // single beat, so last is always set
  always_comb begin
    r_o.id   = hold.id;
    r_o.data = hold.data;
    r_o.resp = hold.resp;
    r_o.last = 1'b1;
    b_o.id   = hold.id;
    b_o.resp = hold.resp;
  end

  always_ff @(posedge clk) begin
    if (load) begin
      hold <= rsp_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      hold_valid <= 1'b0;
    end else if (load) begin
      hold_valid <= 1'b1;
    end else if (out_acc) begin
      hold_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/axi_mem_soc.sv
`default_nettype none
`timescale 1ns/1ps

module axi_mem_soc (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              ar_valid_i,
  input  axi_pkg::axi_ar_t  ar_i,
  output logic              ar_ready_o,
  input  logic              aw_valid_i,
  input  axi_pkg::axi_aw_t  aw_i,
  output logic              aw_ready_o,
  input  logic              w_valid_i,
  input  axi_pkg::axi_w_t   w_i,
  output logic              w_ready_o,
  output logic              r_valid_o,
  output axi_pkg::axi_r_t   r_o,
  input  logic              r_ready_i,
  output logic              b_valid_o,
  output axi_pkg::axi_b_t   b_o,
  input  logic              b_ready_i,
  output logic [7:0]        uart_char_o,
  output logic              uart_valid_o,
  input  logic              uart_ready_i
);

  import axi_pkg::*;

  logic       go;
  logic       req_valid;
  logic       req_ready;
  mem_req_t   req;
  logic       rsp_valid;
  logic       rsp_ready;
  mem_rsp_t   rsp;
  logic       chr_valid;
  logic       chr_ready;
  logic [7:0] chr;

  stall_lfsr stall_lfsr_i (
    .clk   (clk),
    .rst_i (rst_i),
    .go_o  (go)
  );

  axi_req_stage axi_req_stage_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .go_i        (go),
    .ar_valid_i  (ar_valid_i),
    .ar_i        (ar_i),
    .ar_ready_o  (ar_ready_o),
    .aw_valid_i  (aw_valid_i),
    .aw_i        (aw_i),
    .aw_ready_o  (aw_ready_o),
    .w_valid_i   (w_valid_i),
    .w_i         (w_i),
    .w_ready_o   (w_ready_o),
    .req_valid_o (req_valid),
    .req_o       (req),
    .req_ready_i (req_ready)
  );

  mem_stage mem_stage_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .rsp_ready_i (rsp_ready),
    .chr_valid_o (chr_valid),
    .chr_o       (chr),
    .chr_ready_i (chr_ready)
  );

  uart_tx_port uart_tx_port_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .chr_valid_i  (chr_valid),
    .chr_i        (chr),
    .chr_ready_o  (chr_ready),
    .uart_char_o  (uart_char_o),
    .uart_valid_o (uart_valid_o),
    .uart_ready_i (uart_ready_i)
  );

  axi_resp_stage axi_resp_stage_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp),
    .rsp_ready_o (rsp_ready),
    .r_valid_o   (r_valid_o),
    .r_o         (r_o),
    .r_ready_i   (r_ready_i),
    .b_valid_o   (b_valid_o),
    .b_o         (b_o),
    .b_ready_i   (b_ready_i)
  );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// File: tests/axi_mem_assert.sv
`default_nettype none
`timescale 1ns/1ps

module axi_mem_assert (
  input logic             clk,
  input logic             rst_i,
  input logic             ar_valid_i,
  input logic             ar_ready_i,
  input logic             aw_valid_i,
  input logic             aw_ready_i,
  input logic             r_valid_i,
  input logic             r_ready_i,
  input axi_pkg::axi_r_t  r_i,
  input logic             b_valid_i,
  input logic             b_ready_i,
  input axi_pkg::axi_b_t  b_i,
  input logic             uart_valid_i,
  input logic             uart_ready_i,
  input logic [7:0]       uart_char_i
);

  logic [7:0] open_cnt;
  logic       req_acc;
  logic       rsp_acc;

  assign req_acc = (ar_valid_i && ar_ready_i) || (aw_valid_i && aw_ready_i);
  assign rsp_acc = (r_valid_i && r_ready_i) || (b_valid_i && b_ready_i);

  // requests accepted but not yet answered
  always_ff @(posedge clk) begin
    if (rst_i) begin
      open_cnt <= 8'd0;
    end else if (req_acc && !rsp_acc) begin
      open_cnt <= open_cnt + 8'd1;
    end else if (rsp_acc && !req_acc) begin
      open_cnt <= open_cnt - 8'd1;
    end
  end

  r_stable: assert property (@(posedge clk) disable iff (rst_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else $error("R beat changed before it was accepted");

  b_stable: assert property (@(posedge clk) disable iff (rst_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
    else $error("B beat changed before it was accepted");

  uart_stable: assert property (@(posedge clk) disable iff (rst_i)
    uart_valid_i && !uart_ready_i |=> uart_valid_i && $stable(uart_char_i))
    else $error("uart character changed before it was taken");

  rsp_has_req: assert property (@(posedge clk) disable iff (rst_i)
    (r_valid_i || b_valid_i) |-> open_cnt != 8'd0)
    else $error("response beat with no accepted request");

  // first reset edge has passed
  quiet_in_reset: assert property (@(posedge clk)
    rst_i && $past(rst_i) |-> !r_valid_i && !b_valid_i && !uart_valid_i)
    else $error("valid output high during reset");

endmodule

bind axi_mem_soc axi_mem_assert axi_mem_assert_i (
  .clk          (clk),
  .rst_i        (rst_i),
  .ar_valid_i   (ar_valid_i),
  .ar_ready_i   (ar_ready_o),
  .aw_valid_i   (aw_valid_i),
  .aw_ready_i   (aw_ready_o),
  .r_valid_i    (r_valid_o),
  .r_ready_i    (r_ready_i),
  .r_i          (r_o),
  .b_valid_i    (b_valid_o),
  .b_ready_i    (b_ready_i),
  .b_i          (b_o),
  .uart_valid_i (uart_valid_o),
  .uart_ready_i (uart_ready_i),
  .uart_char_i  (uart_char_o)
);

`default_nettype wire

// File: tests/tb_axi_mem.sv
`default_nettype none
`timescale 1ns/1ps

`include "soc_defs.svh"

module tb_axi_mem;

  import axi_pkg::*;

  localparam int          RESET_CYCLES  = 16;
  localparam int          CYCLES_PER_OP = 40;
  localparam int          UART_HOLD     = 60;
  localparam logic [31:0] MEM_BASE      = `SOC_MEM_BASE;
  localparam logic [31:0] MEM_END       = `SOC_MEM_BASE + (`SOC_MEM_WORDS * 8);
  localparam logic        RD            = 1'b0;
  localparam logic        WR            = 1'b1;

  typedef struct packed {
    logic [2:0]  grp;
    logic        is_wr;
    logic [31:0] addr;
    logic [7:0]  len;
    logic [63:0] data;
    logic [7:0]  strb;
    axi_resp_e   resp;
  } op_t;

  typedef struct packed {
    logic        is_wr;
    logic [3:0]  id;
    axi_resp_e   resp;
    logic        chk;
    logic [63:0] data;
  } exp_t;

  logic       clk;
  logic       rst_i;
  logic       ar_valid_i;
  axi_ar_t    ar_i;
  logic       ar_ready_o;
  logic       aw_valid_i;
  axi_aw_t    aw_i;
  logic       aw_ready_o;
  logic       w_valid_i;
  axi_w_t     w_i;
  logic       w_ready_o;
  logic       r_valid_o;
  axi_r_t     r_o;
  logic       r_ready_i;
  logic       b_valid_o;
  axi_b_t     b_o;
  logic       b_ready_i;
  logic [7:0] uart_char_o;
  logic       uart_valid_o;
  logic       uart_ready_i;

  op_t         ops [$];
  exp_t        exp_q [$];
  logic [7:0]  uart_exp [$];
  logic [63:0] ref_mem [`SOC_MEM_WORDS];
  int          n_sent;
  int          n_done;
  int          n_uart_seen;
  int          err_cnt;
  int          cycle;
  int          limit;
  int          hold_until;
  integer      seed;

  tb_clock tb_clock_i (
    .clk (clk)
  );

  axi_mem_soc axi_mem_soc_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .ar_valid_i   (ar_valid_i),
    .ar_i         (ar_i),
    .ar_ready_o   (ar_ready_o),
    .aw_valid_i   (aw_valid_i),
    .aw_i         (aw_i),
    .aw_ready_o   (aw_ready_o),
    .w_valid_i    (w_valid_i),
    .w_i          (w_i),
    .w_ready_o    (w_ready_o),
    .r_valid_o    (r_valid_o),
    .r_o          (r_o),
    .r_ready_i    (r_ready_i),
    .b_valid_o    (b_valid_o),
    .b_o          (b_o),
    .b_ready_i    (b_ready_i),
    .uart_char_o  (uart_char_o),
    .uart_valid_o (uart_valid_o),
    .uart_ready_i (uart_ready_i)
  );

  task automatic add_op(input logic [2:0] grp, input logic is_wr, input logic [31:0] addr,
                        input logic [7:0] len, input logic [63:0] data, input logic [7:0] strb,
                        input axi_resp_e resp);
    op_t op;
    op.grp   = grp;
    op.is_wr = is_wr;
    op.addr  = addr;
    op.len   = len;
    op.data  = data;
    op.strb  = strb;
    op.resp  = resp;
    ops.push_back(op);
  endtask

  task automatic build_table();
    add_op(3'd1, WR, 32'h8000_0000, 8'd0, 64'h0123_4567_89ab_cdef, 8'hff, OKAY);
    add_op(3'd1, WR, 32'h8000_0008, 8'd0, 64'hfedc_ba98_7654_3210, 8'hff, OKAY);
    add_op(3'd1, WR, 32'h8000_0000, 8'd0, 64'haaaa_bbbb_cccc_dddd, 8'h0f, OKAY);
    add_op(3'd1, WR, 32'h8000_07f8, 8'd0, 64'h1122_3344_5566_7788, 8'hff, OKAY);
    add_op(3'd1, WR, 32'h8000_07f8, 8'd0, 64'h9900_0000_0000_00ee, 8'h81, OKAY);
    add_op(3'd1, RD, 32'h8000_0000, 8'd0, 64'd0, 8'h00, OKAY);
    add_op(3'd1, RD, 32'h8000_0008, 8'd0, 64'd0, 8'h00, OKAY);
    add_op(3'd1, RD, 32'h8000_07f8, 8'd0, 64'd0, 8'h00, OKAY);
    // bursts are refused and leave memory alone
    add_op(3'd2, WR, 32'h8000_0008, 8'd3, 64'hffff_ffff_ffff_ffff, 8'hff, SLVERR);
    add_op(3'd2, RD, 32'h8000_0000, 8'd1, 64'd0, 8'h00, SLVERR);
    add_op(3'd2, RD, 32'h8000_0008, 8'd0, 64'd0, 8'h00, OKAY);
    add_op(3'd3, RD, 32'h0000_1000, 8'd0, 64'd0, 8'h00, DECERR);
    add_op(3'd3, WR, 32'h2000_0000, 8'd0, 64'h5a5a_5a5a_5a5a_5a5a, 8'hff, DECERR);
    add_op(3'd3, RD, 32'h1000_0004, 8'd0, 64'd0, 8'h00, DECERR);
    add_op(3'd3, WR, 32'h8000_0800, 8'd0, 64'h1234_5678_1234_5678, 8'hff, DECERR);
    // more characters than the uart fifo holds
    add_op(3'd4, WR, 32'h1000_0000, 8'd0, 64'h48, 8'h01, OKAY);
    add_op(3'd4, WR, 32'h1000_0000, 8'd0, 64'h65, 8'h01, OKAY);
    add_op(3'd4, WR, 32'h1000_0000, 8'd0, 64'h6c, 8'h01, OKAY);
    add_op(3'd4, WR, 32'h1000_0000, 8'd0, 64'h6c, 8'h01, OKAY);
    add_op(3'd4, WR, 32'h1000_0000, 8'd0, 64'h6f, 8'h01, OKAY);
    add_op(3'd4, WR, 32'h1000_0000, 8'd0, 64'h21, 8'h01, OKAY);
    add_op(3'd4, WR, 32'h1000_0000, 8'd0, 64'h0a, 8'h01, OKAY);
    add_op(3'd4, RD, 32'h1000_0000, 8'd0, 64'd0, 8'h00, OKAY);
    add_op(3'd5, WR, 32'h8000_0010, 8'd0, 64'hcafe_f00d_dead_beef, 8'hff, OKAY);
    add_op(3'd5, RD, 32'h8000_0010, 8'd0, 64'd0, 8'h00, OKAY);
    add_op(3'd5, WR, 32'h8000_0018, 8'd0, 64'h0f0f_0f0f_0f0f_0f0f, 8'hff, OKAY);
    add_op(3'd5, WR, 32'h8000_0018, 8'd0, 64'h7777_6666_5555_4444, 8'h3c, OKAY);
    add_op(3'd5, RD, 32'h8000_0018, 8'd0, 64'd0, 8'h00, OKAY);
    add_op(3'd5, RD, 32'h8000_0000, 8'd0, 64'd0, 8'h00, OKAY);
    add_op(3'd5, WR, 32'h8000_0010, 8'd0, 64'h1357_9bdf_0246_8ace, 8'hf0, OKAY);
    add_op(3'd5, RD, 32'h8000_0010, 8'd0, 64'd0, 8'h00, OKAY);
  endtask

  function automatic string grp_label(input logic [2:0] grp);
    case (grp)
      3'd1:    return "sram writes and reads";
      3'd2:    return "burst refused";
      3'd3:    return "decode error";
      3'd4:    return "uart output";
      default: return "interleaved back-pressure";
    endcase
  endfunction

  // byte lanes with a strobe bit take the new data
  function automatic logic [63:0] merge_strobe(input logic [63:0] old, input logic [63:0] data,
                                               input logic [7:0] strb);
    logic [63:0] res;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic record_expected(input op_t op, input logic [3:0] id);
    exp_t                           e;
    logic [31:0]                    off;
    logic [`SOC_MEM_WORDS_LOG2-1:0] w;
    logic                           in_mem;
    off    = op.addr - MEM_BASE;
    w      = off[`SOC_MEM_WORDS_LOG2+2:3];
    in_mem = (op.addr >= MEM_BASE) && (op.addr < MEM_END);
    e.is_wr = op.is_wr;
    e.id    = id;
    e.resp  = op.resp;
    e.chk   = 1'b0;
    e.data  = 64'd0;
    if (op.resp == OKAY && in_mem) begin
      if (op.is_wr) begin
        ref_mem[w] = merge_strobe(ref_mem[w], op.data, op.strb);
      end else begin
        e.chk  = 1'b1;
        e.data = ref_mem[w];
      end
    end else if (op.resp == OKAY) begin
      // uart reads give zero
      if (op.is_wr) begin
        uart_exp.push_back(op.data[7:0]);
      end else begin
        e.chk = 1'b1;
      end
    end
    exp_q.push_back(e);
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send_op(input op_t op);
    logic [3:0] id;
    logic       acc;
    id = n_sent[3:0];
    record_expected(op, id);
    n_sent++;
    if (op.is_wr) begin
      aw_i.id    = id;
      aw_i.addr  = op.addr;
      aw_i.len   = op.len;
      aw_i.size  = 3'd3;
      aw_i.burst = 2'b01;
      w_i.data   = op.data;
      w_i.strb   = op.strb;
      w_i.last   = 1'b1;
      aw_valid_i = 1'b1;
      w_valid_i  = 1'b1;
    end else begin
      ar_i.id    = id;
      ar_i.addr  = op.addr;
      ar_i.len   = op.len;
      ar_i.size  = 3'd3;
      ar_i.burst = 2'b01;
      ar_valid_i = 1'b1;
    end
    acc = 1'b0;
    while (!acc) begin
      #1;
      acc = op.is_wr ? (aw_ready_o && w_ready_o) : ar_ready_o;
      @(negedge clk);
    end
    ar_valid_i = 1'b0;
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
  endtask

  task automatic log_fail(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic check_beat(input logic is_wr, input logic [3:0] id, input axi_resp_e resp,
                            input logic [63:0] data, input logic last);
    exp_t e;
    if (n_done >= exp_q.size()) begin
      log_fail($sformatf("%s beat with no request outstanding", is_wr ? "B" : "R"));
    end else begin
      e = exp_q[n_done];
      n_done++;
      if (is_wr != e.is_wr) begin
        log_fail($sformatf("response %0d came on the wrong channel", n_done - 1));
      end
      if (id != e.id) begin
        log_fail($sformatf("id %0h, expected %0h", id, e.id));
      end
      if (resp != e.resp) begin
        log_fail($sformatf("id %0h resp %0d, expected %0d", id, resp, e.resp));
      end
      if (!is_wr && !last) begin
        log_fail($sformatf("id %0h R beat without last", id));
      end
      if (e.chk && data !== e.data) begin
        log_fail($sformatf("id %0h data %h, expected %h", id, data, e.data));
      end
    end
  endtask

  task automatic check_char(input logic [7:0] chr);
    if (n_uart_seen >= uart_exp.size()) begin
      log_fail($sformatf("unexpected uart character %h", chr));
    end else begin
      if (chr != uart_exp[n_uart_seen]) begin
        log_fail($sformatf("uart char %h, expected %h", chr, uart_exp[n_uart_seen]));
      end
      n_uart_seen++;
    end
  endtask

  initial begin : backpressure
    logic uart_rnd;
    seed         = 32'hc048;
    r_ready_i    = 1'b0;
    b_ready_i    = 1'b0;
    uart_ready_i = 1'b0;
    forever begin
      @(negedge clk);
      r_ready_i    = ($random(seed) & 3) != 0;
      b_ready_i    = ($random(seed) & 3) != 0;
      uart_rnd     = ($random(seed) & 1) != 0;
      uart_ready_i = (cycle >= hold_until) && uart_rnd;
    end
  end

  // beats are sampled before the rising edge that completes them
  initial begin : monitor
    n_done      = 0;
    n_uart_seen = 0;
    err_cnt     = 0;
    forever begin
      @(negedge clk);
      #1;
      // aw and w are taken together
      if (aw_ready_o !== w_ready_o) begin
        log_fail($sformatf("aw_ready %b and w_ready %b differ", aw_ready_o, w_ready_o));
      end
      if (r_valid_o && r_ready_i) begin
        check_beat(1'b0, r_o.id, r_o.resp, r_o.data, r_o.last);
      end
      if (b_valid_o && b_ready_i) begin
        check_beat(1'b1, b_o.id, b_o.resp, 64'd0, 1'b1);
      end
      if (uart_valid_o && uart_ready_i) begin
        check_char(uart_char_o);
      end
    end
  end

  initial begin : watchdog
    cycle = 0;
    while (limit == 0 || cycle < limit) begin
      @(posedge clk);
      cycle++;
    end
    $display("timeout: run did not finish in %0d cycles, %0d of %0d responses seen",
             limit, n_done, exp_q.size());
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    int grp_err;
    rst_i      = 1'b1;
    ar_valid_i = 1'b0;
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    ar_i       = '0;
    aw_i       = '0;
    w_i        = '0;
    n_sent     = 0;
    hold_until = 0;
    grp_err    = 0;
    build_table();
    limit = ops.size() * CYCLES_PER_OP + RESET_CYCLES;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_i = 1'b0;
    for (int i = 0; i < ops.size(); i++) begin
      if (i == 0 || ops[i].grp != ops[i-1].grp) begin
        grp_err = err_cnt;
        // sink stalls so the uart fifo fills
        if (ops[i].grp == 3'd4) begin
          hold_until = cycle + UART_HOLD;
        end
      end
      send_op(ops[i]);
      if (i == ops.size() - 1 || ops[i+1].grp != ops[i].grp) begin
        while (n_done != exp_q.size() || n_uart_seen != uart_exp.size()) begin
          @(negedge clk);
        end
        $display("test %0d %s: %0d errors", ops[i].grp, grp_label(ops[i].grp),
                 err_cnt - grp_err);
      end
    end
    // stray beats would show up here
    repeat (10) @(negedge clk);
    $display("ops %0d, responses %0d, uart chars %0d, errors %0d",
             ops.size(), n_done, n_uart_seen, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/axi_pkg.sv
verilog/stall_lfsr.sv
verilog/axi_req_stage.sv
verilog/mem_stage.sv
verilog/uart_tx_port.sv
verilog/axi_resp_stage.sv
verilog/axi_mem_soc.sv
tests/tb_clock.sv
tests/axi_mem_assert.sv
tests/tb_axi_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the axi memory testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_axi_mem \
  -f filelist.f \
  -o sim_axi_mem

./obj_dir/sim_axi_mem | tee sim.log

if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
